// ==== logic/timer_macros.svh ====
// --------------------
// timer macros
// counter and bus widths, register map of the timer
// --------------------

`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// widths
`define TIMER_WIDTH     32
`define BUS_ADDR_WIDTH  8
`define BUS_DATA_WIDTH  32

// register map
`define ADDR_CTRL       8'h08
`define ADDR_STATUS     8'h09
`define ADDR_PRESCALER  8'h0a
`define ADDR_TIMER      8'h0b
`define ADDR_CURR       8'h0c

// bit positions inside ctrl and status words
`define CTRL_START_BIT   0
`define CTRL_STOP_BIT    1
`define STATUS_READY_BIT 0

`endif

// ==== logic/timer_pkg.sv ====
// --------------------
// timer package
// shared vector types and the core state encoding
// --------------------

`include "timer_macros.svh"

package timer_pkg;

  // one counter value
  typedef logic [`TIMER_WIDTH-1:0] count_t;

  // register bus address and data word
  typedef logic [`BUS_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`BUS_DATA_WIDTH-1:0] data_t;

  // core control states
  typedef enum logic [1:0] {
    core_idle     = 2'h0,
    core_prescale = 2'h1,
    core_count    = 2'h2
  } core_state_t;

endpackage

// ==== logic/timer_ctrl_if.sv ====
// --------------------
// timer control interface
// init values, strobes and status between regs, core and readback
// --------------------

interface timer_ctrl_if
  import timer_pkg::*;
();

  // from the register block
  count_t prescaler_init;
  count_t timer_init;
  logic   start;
  logic   stop;

  // from the core
  count_t curr_timer;
  logic   ready;

  // input side, gates init writes on ready
  modport regs (
    output prescaler_init, timer_init, start, stop,
    input  ready
  );

  modport core (
    input  prescaler_init, timer_init, start, stop,
    output curr_timer, ready
  );

  // output side, observes only
  modport readback (
    input prescaler_init, timer_init, curr_timer, ready
  );

endinterface

// ==== logic/timer_regs.sv ====
// --------------------
// timer register block
// holds the init values and decodes ctrl writes into strobes
// --------------------

`include "timer_macros.svh"

module timer_regs
  import timer_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       cs,
  input  logic       we,
  input  addr_t      address,
  input  data_t      write_data,
  timer_ctrl_if.regs ctrl
);

  // --------------------
  // write decode
  // --------------------
  logic   bus_write;
  logic   write_ctrl;
  logic   write_prescaler;
  logic   write_timer;

  count_t prescaler_init_reg;
  count_t timer_init_reg;

  assign bus_write       = cs && we;
  assign write_ctrl      = bus_write && (address == `ADDR_CTRL);

  // init values only change while the core sits idle
  assign write_prescaler = bus_write && ctrl.ready && (address == `ADDR_PRESCALER);
  assign write_timer     = bus_write && ctrl.ready && (address == `ADDR_TIMER);

  // --------------------
  // strobes
  // --------------------
  // combinational, so the core samples them at the write edge
  assign ctrl.start = write_ctrl && write_data[`CTRL_START_BIT];
  assign ctrl.stop  = write_ctrl && write_data[`CTRL_STOP_BIT];

  // --------------------
  // init registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prescaler_init_reg <= '0;
      timer_init_reg     <= '0;
    end else begin
      if (write_prescaler) begin
        prescaler_init_reg <= write_data;
      end

      if (write_timer) begin
        timer_init_reg <= write_data;
      end
    end
  end

  // to core and readback
  assign ctrl.prescaler_init = prescaler_init_reg;
  assign ctrl.timer_init     = timer_init_reg;

endmodule

// ==== logic/timer_core.sv ====
// --------------------
// timer core
// prescaler and timer down-counters with their control FSM
// --------------------

module timer_core
  import timer_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  timer_ctrl_if.core ctrl
);

  // --------------------
  // registers, next values, write enables
  // --------------------
  logic        ready_reg;
  logic        ready_new;
  logic        ready_we;

  count_t      prescaler_reg;
  count_t      prescaler_new;
  logic        prescaler_we;
  logic        prescaler_set;
  logic        prescaler_dec;

  count_t      timer_reg;
  count_t      timer_new;
  logic        timer_we;
  logic        timer_set;
  logic        timer_dec;

  core_state_t state_reg;
  core_state_t state_new;
  logic        state_we;

  // outputs straight from registers
  assign ctrl.curr_timer = timer_reg;
  assign ctrl.ready      = ready_reg;

  // register update
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg     <= 1'b1;
      prescaler_reg <= '0;
      timer_reg     <= '0;
      state_reg     <= core_idle;
    end else begin
      if (ready_we) begin
        ready_reg <= ready_new;
      end
      if (prescaler_we) begin
        prescaler_reg <= prescaler_new;
      end
      if (timer_we) begin
        timer_reg <= timer_new;
      end
      if (state_we) begin
        state_reg <= state_new;
      end
    end
  end

  // prescaler counter, set wins over decrement
  always_comb begin
    prescaler_new = '0;
    prescaler_we  = 1'b0;
    if (prescaler_set) begin
      prescaler_new = ctrl.prescaler_init;
      prescaler_we  = 1'b1;
    end else if (prescaler_dec) begin
      prescaler_new = prescaler_reg - 1'b1;
      prescaler_we  = 1'b1;
    end
  end

  // timer counter
  always_comb begin
    timer_new = '0;
    timer_we  = 1'b0;
    if (timer_set) begin
      timer_new = ctrl.timer_init;
      timer_we  = 1'b1;
    end else if (timer_dec) begin
      timer_new = timer_reg - 1'b1;
      timer_we  = 1'b1;
    end
  end

  // --------------------
  // control FSM
  // --------------------
  always_comb begin
    ready_new     = 1'b0;
    ready_we      = 1'b0;
    prescaler_set = 1'b0;
    prescaler_dec = 1'b0;
    timer_set     = 1'b0;
    timer_dec     = 1'b0;
    state_new     = core_idle;
    state_we      = 1'b0;

    case (state_reg)
      core_idle: begin
        // stop has no effect here
        if (ctrl.start) begin
          ready_we      = 1'b1;
          prescaler_set = 1'b1;
          timer_set     = 1'b1;
          state_new     = core_prescale;
          state_we      = 1'b1;
        end
      end

      core_prescale: begin
        if (ctrl.stop) begin
          ready_new = 1'b1;
          ready_we  = 1'b1;
          state_we  = 1'b1;
        end else if (prescaler_reg == '0) begin
          state_new = core_count;
          state_we  = 1'b1;
        end else begin
          prescaler_dec = 1'b1;
        end
      end

      core_count: begin
        // timer at zero or stop both end the run
        if (ctrl.stop || (timer_reg == '0)) begin
          ready_new = 1'b1;
          ready_we  = 1'b1;
          state_we  = 1'b1;
        end else begin
          prescaler_set = 1'b1;
          timer_dec     = 1'b1;
          state_new     = core_prescale;
          state_we      = 1'b1;
        end
      end

      default: begin
        // unused encoding, back to idle
        ready_new = 1'b1;
        ready_we  = 1'b1;
        state_we  = 1'b1;
      end
    endcase
  end

endmodule

// ==== logic/timer_readback.sv ====
// --------------------
// timer readback
// registered read mux over status, init values and count
// --------------------

`include "timer_macros.svh"

module timer_readback
  import timer_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  logic           cs,
  input  logic           we,
  input  addr_t          address,
  output data_t          read_data,
  timer_ctrl_if.readback ctrl
);

  data_t status_word;
  data_t read_word;

  // ready in the low bit, rest zero
  always_comb begin
    status_word                    = '0;
    status_word[`STATUS_READY_BIT] = ctrl.ready;
  end

  // select the addressed word
  always_comb begin
    case (address)
      `ADDR_STATUS:    read_word = status_word;
      `ADDR_PRESCALER: read_word = ctrl.prescaler_init;
      `ADDR_TIMER:     read_word = ctrl.timer_init;
      `ADDR_CURR:      read_word = ctrl.curr_timer;
      // ctrl is write only, unmapped reads zero
      default:         read_word = '0;
    endcase
  end

  // --------------------
  // output register
  // --------------------
  // valid the cycle after the read, held until the next one
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      read_data <= '0;
    end else if (cs && !we) begin
      read_data <= read_word;
    end
  end

endmodule

// ==== logic/timer_top.sv ====
// --------------------
// timer top
// register block, core and readback on one control interface
// --------------------

module timer_top
  import timer_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,

  // register bus
  input  logic  cs,
  input  logic  we,
  input  addr_t address,
  input  data_t write_data,
  output data_t read_data,

  // high while idle
  output logic  ready
);

  timer_ctrl_if ctrl ();

  // input side
  timer_regs u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .ctrl       (ctrl)
  );

  // counters and FSM
  timer_core u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl)
  );

  // output side
  timer_readback u_readback (
    .clk       (clk),
    .reset_n   (reset_n),
    .cs        (cs),
    .we        (we),
    .address   (address),
    .read_data (read_data),
    .ctrl      (ctrl)
  );

  assign ready = ctrl.ready;

endmodule

// ==== testbench/timer_tb.sv ====
// --------------------
// timer testbench
// file driven countdown, stop and register checks on timer_top
// --------------------

`include "timer_macros.svh"

module timer_tb
  import timer_pkg::*;
();

  logic  clk = 1'b0;
  logic  reset_n;
  logic  cs;
  logic  we;
  addr_t address;
  data_t write_data;
  data_t read_data;
  logic  ready;

  // stimulus lines and run bookkeeping
  int          op_q[$];
  int          p_q[$];
  int          t_q[$];
  int          k_q[$];
  int          exp_q[$];
  int          timeout_cycles = 0;
  int          cycle_count = 0;
  int          start_cycle;
  logic [31:0] lfsr_state = 32'hed6f;

  timer_top u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .ready      (ready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_count(string name, count_t expected, count_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_data(string name, data_t expected, data_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %08h got %08h", $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_ready(string name, bit expected, bit actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t: %s expected %0b got %0b", $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // fibonacci lfsr on taps 32 22 2 1
  // one step for every bit taken
  function automatic data_t random_word();
    data_t word;
    logic  fb;
    word = '0;
    for (int i = 0; i < `BUS_DATA_WIDTH; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      word       = {word[`BUS_DATA_WIDTH-2:0], fb};
    end
    return word;
  endfunction

  // --------------------
  // bus tasks
  // --------------------
  // called at a falling edge and return one falling edge later
  task automatic write_reg(addr_t addr, data_t data);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  // read data registered at the edge and sampled at the next falling edge
  task automatic read_reg(addr_t addr, output data_t data);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    @(negedge clk);
    cs   = 1'b0;
    data = read_data;
  endtask

  // init writes while idle must read back exactly
  task automatic load_init(int p, int t);
    data_t rd;
    write_reg(`ADDR_PRESCALER, p);
    write_reg(`ADDR_TIMER, t);
    read_reg(`ADDR_PRESCALER, rd);
    check_data("prescaler readback", p, rd);
    read_reg(`ADDR_TIMER, rd);
    check_data("timer readback", t, rd);
  endtask

  // ready drops at the start edge
  task automatic start_timer();
    write_reg(`ADDR_CTRL, 32'h1);
    check_ready("ready after start", 1'b0, ready);
    start_cycle = cycle_count;
  endtask

  // full countdown with optional ignored writes while it runs
  task automatic run_countdown(int p, int t, bit with_writes);
    data_t rd;
    load_init(p, t);
    start_timer();
    if (with_writes) begin
      write_reg(`ADDR_PRESCALER, random_word());
      write_reg(`ADDR_TIMER, random_word());
      read_reg(`ADDR_PRESCALER, rd);
      check_data("prescaler while running", p, rd);
      read_reg(`ADDR_TIMER, rd);
      check_data("timer while running", t, rd);
    end
    // wait for ready to rise
    while (ready !== 1'b1) begin
      @(negedge clk);
    end
    check_count("countdown cycles", (t + 1) * (p + 2), cycle_count - start_cycle);
    read_reg(`ADDR_CURR, rd);
    check_count("curr after countdown", 0, rd);
    read_reg(`ADDR_STATUS, rd);
    check_data("status after countdown", 32'h1, rd);
  endtask

  // stop k cycles after the start edge and then a full run
  task automatic stop_run(int p, int t, int k, int expected);
    data_t rd;
    load_init(p, t);
    start_timer();
    repeat (k - 1) @(negedge clk);
    write_reg(`ADDR_CTRL, 32'h2);
    check_ready("ready after stop", 1'b1, ready);
    read_reg(`ADDR_CURR, rd);
    check_count("curr after stop", expected, rd);
    run_countdown(p, t, 1'b0);
  endtask

  task automatic load_stimulus();
    int    fd;
    int    op, p, t, k, e;
    int    total;
    string line;
    fd = $fopen("testbench/timer_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("Verification failed");
      $fatal(1);
    end
    total = 16 + 50;
    while ($fgets(line, fd) > 0) begin
      // comment and blank lines do not scan
      if ($sscanf(line, "%d %d %d %d %d", op, p, t, k, e) == 5) begin
        op_q.push_back(op);
        p_q.push_back(p);
        t_q.push_back(t);
        k_q.push_back(k);
        exp_q.push_back(e);
        total += (t + 1) * (p + 2) + 50;
      end
    end
    $fclose(fd);
    timeout_cycles = total;
  endtask

  // --------------------
  // watchdog
  // --------------------
  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout, the timer never returned to ready");
    $display("Verification failed");
    $fatal(1);
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    data_t rd;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    load_stimulus();
    repeat (16) @(negedge clk);
    reset_n = 1'b1;

    // reset state
    check_ready("ready after reset", 1'b1, ready);
    read_reg(`ADDR_STATUS, rd);
    check_data("status after reset", 32'h1, rd);
    read_reg(`ADDR_PRESCALER, rd);
    check_data("prescaler after reset", 32'h0, rd);
    read_reg(`ADDR_TIMER, rd);
    check_data("timer after reset", 32'h0, rd);
    read_reg(`ADDR_CURR, rd);
    check_count("curr after reset", 0, rd);

    foreach (op_q[i]) begin
      case (op_q[i])
        1: run_countdown(p_q[i], t_q[i], 1'b0);
        2: run_countdown(p_q[i], t_q[i], 1'b1);
        3: stop_run(p_q[i], t_q[i], k_q[i], exp_q[i]);
        default: begin
          $display("unknown operation %0d in the stimulus file", op_q[i]);
          $display("Verification failed");
          $fatal(1);
        end
      endcase
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== testbench/timer_stim.txt ====
# op prescaler timer stop_delay expected_count
# op 1 countdown, 2 countdown with writes while running, 3 stop after stop_delay cycles
1 0 0 0 0
1 1 0 0 0
1 0 3 0 0
1 3 2 0 0
1 5 4 0 0
2 2 3 0 0
2 4 1 0 0
3 3 4 7 3
3 0 5 3 4
3 2 3 1 3
3 1 6 11 3

// ==== src.f ====
+incdir+logic
logic/timer_pkg.sv
logic/timer_ctrl_if.sv
logic/timer_regs.sv
logic/timer_core.sv
logic/timer_readback.sv
logic/timer_top.sv
testbench/timer_tb.sv

// ==== Bender.yml ====
package:
  name: timer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/timer_pkg.sv
      - logic/timer_ctrl_if.sv
      - logic/timer_regs.sv
      - logic/timer_core.sv
      - logic/timer_readback.sv
      - logic/timer_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/timer_tb.sv
